// ==== verilog/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

	// AXI4-Lite bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// Register indices taken from address bits 3 to 2
	localparam logic [1:0] REG_CTRL   = 2'd0;
	localparam logic [1:0] REG_STATUS = 2'd1;
	localparam logic [1:0] REG_START  = 2'd2;
	localparam logic [1:0] REG_STOP   = 2'd3;

	// Control register fields
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_DEST_BIT  = 1;
	// Status register exec flag, boot source sits just above it
	localparam int STAT_EXEC_BIT  = 0;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Strapped boot source
	typedef enum logic [1:0] {
		BOOT_SPI  = 2'd0,
		BOOT_SRAM = 2'd1,
		BOOT_DDR  = 2'd2
	} boot_src_e;

endpackage

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// Bytes per copied word
	localparam int WORD_BYTES = 4;

	// Low address bits kept when mapping into each RAM
	localparam int SRAM_OFFS_W = 17;
	localparam int DDR_OFFS_W  = 28;
	// Top nibble of every DDR address
	localparam logic [3:0] DDR_REGION = 4'd1;

	// Where the code copy goes
	typedef enum logic {
		DEST_SRAM = 1'b0,
		DEST_DDR  = 1'b1
	} copy_dest_e;

	// Stall FSM states
	typedef enum logic [2:0] {
		ARB_IDLE,
		ARB_WAIT_BOTH,
		ARB_WAIT_DATA,
		ARB_WAIT_INSTR,
		ARB_ACK
	} arb_state_e;

	// Copy FSM states
	typedef enum logic [2:0] {
		CP_IDLE,
		CP_READ_ROM,
		CP_WRITE_RAM,
		CP_INCR,
		CP_DONE
	} copy_state_e;

endpackage

`default_nettype wire

// ==== verilog/axil_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_csr (
	input  logic                           clk_i,
	input  logic                           rst_ni,
	input  logic                           awvalid_i,
	output logic                           awready_o,
	input  logic [csr_pkg::ADDR_W-1:0]     awaddr_i,
	input  logic                           wvalid_i,
	output logic                           wready_o,
	input  logic [csr_pkg::DATA_W-1:0]     wdata_i,
	input  logic [csr_pkg::STRB_W-1:0]     wstrb_i,
	output logic                           bvalid_o,
	input  logic                           bready_i,
	output logic [1:0]                     bresp_o,
	input  logic                           arvalid_i,
	output logic                           arready_o,
	input  logic [csr_pkg::ADDR_W-1:0]     araddr_i,
	output logic                           rvalid_o,
	input  logic                           rready_i,
	output logic [csr_pkg::DATA_W-1:0]     rdata_o,
	output logic [1:0]                     rresp_o,
	input  csr_pkg::boot_src_e             boot_src_i,
	input  logic                           copy_done_i,
	output logic                           start_copy_o,
	output mem_pkg::copy_dest_e            copy_dest_o,
	output logic [csr_pkg::ADDR_W-1:0]     start_addr_o,
	output logic [csr_pkg::ADDR_W-1:0]     stop_addr_o,
	output logic                           exec_from_copy_o
);

	logic [csr_pkg::DATA_W-1:0] ctrl_q, start_q, stop_q;
	logic                       exec_q;
	logic                       wr_accept, rd_accept;
	logic [csr_pkg::DATA_W-1:0] wmask, rd_val;

	// Both write channels together, only with no B response pending
	assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
	assign rd_accept = arvalid_i && !rvalid_o;
	assign awready_o = wr_accept;
	assign wready_o  = wr_accept;
	assign arready_o = rd_accept;
	assign bresp_o   = csr_pkg::RESP_OKAY;
	assign rresp_o   = csr_pkg::RESP_OKAY;

	// Expand byte strobes into a bit mask
	always_comb begin
		for (int b = 0; b < csr_pkg::STRB_W; b++) begin
			wmask[8*b +: 8] = {8{wstrb_i[b]}};
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			ctrl_q   <= '0;
			start_q  <= '0;
			stop_q   <= '0;
			exec_q   <= 1'b0;
			bvalid_o <= 1'b0;
		end else begin
			if (wr_accept) begin
				// Status index falls through to default and is dropped
				case (awaddr_i[3:2])
					csr_pkg::REG_CTRL:  ctrl_q  <= (ctrl_q & ~wmask) | (wdata_i & wmask);
					csr_pkg::REG_START: start_q <= (start_q & ~wmask) | (wdata_i & wmask);
					csr_pkg::REG_STOP:  stop_q  <= (stop_q & ~wmask) | (wdata_i & wmask);
					default: begin
					end
				endcase
				bvalid_o <= 1'b1;
			end else if (bready_i) begin
				bvalid_o <= 1'b0;
			end
			// Copier finished, drop start and run from the copy
			if (copy_done_i) begin
				ctrl_q[csr_pkg::CTRL_START_BIT] <= 1'b0;
				exec_q <= 1'b1;
			end
		end
	end

	// Read mux
	always_comb begin
		case (araddr_i[3:2])
			csr_pkg::REG_CTRL:   rd_val = ctrl_q;
			csr_pkg::REG_STATUS: rd_val = {29'd0, boot_src_i, exec_q};
			csr_pkg::REG_START:  rd_val = start_q;
			default:             rd_val = stop_q;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			rvalid_o <= 1'b0;
		end else if (rd_accept) begin
			rvalid_o <= 1'b1;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	// Read data captured with the address
	always_ff @(posedge clk_i) begin
		if (rd_accept) begin
			rdata_o <= rd_val;
		end
	end

	assign start_copy_o     = ctrl_q[csr_pkg::CTRL_START_BIT];
	assign copy_dest_o      = mem_pkg::copy_dest_e'(ctrl_q[csr_pkg::CTRL_DEST_BIT]);
	assign start_addr_o     = start_q;
	assign stop_addr_o      = stop_q;
	assign exec_from_copy_o = exec_q;

	// Responses are held until the master takes them
	a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bvalid_o && !bready_i |=> bvalid_o);
	a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

`default_nettype wire

// ==== verilog/access_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module access_arbiter (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  logic                       cpu_instr_rd_i,
	input  logic                       cpu_data_rd_i,
	input  logic                       cpu_data_wr_i,
	input  logic                       copy_busy_i,
	input  logic                       instr_capture_i,
	input  logic                       instr_ready_i,
	input  logic [csr_pkg::DATA_W-1:0] instr_data_i,
	input  logic                       data_ready_i,
	input  logic [csr_pkg::DATA_W-1:0] data_rdata_i,
	output logic                       arb_instr_rd_o,
	output logic                       arb_data_rd_o,
	output logic                       arb_data_wr_o,
	output mem_pkg::arb_state_e        arb_state_o,
	output logic [csr_pkg::DATA_W-1:0] instr_word_o,
	output logic [csr_pkg::DATA_W-1:0] data_word_o
);

	mem_pkg::arb_state_e state_q, state_d;
	logic                both_req;
	logic                instr_en, data_en;

	// Only simultaneous fetch and data access needs arbitration
	assign both_req = cpu_instr_rd_i && (cpu_data_rd_i || cpu_data_wr_i) && !copy_busy_i;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			state_q <= mem_pkg::ARB_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_pkg::ARB_IDLE: begin
				// Both ready at once needs no wait
				if (both_req) begin
					if (!instr_ready_i && !data_ready_i) begin
						state_d = mem_pkg::ARB_WAIT_BOTH;
					end else if (!instr_ready_i) begin
						state_d = mem_pkg::ARB_WAIT_INSTR;
					end else if (!data_ready_i) begin
						state_d = mem_pkg::ARB_WAIT_DATA;
					end
				end
			end
			mem_pkg::ARB_WAIT_BOTH: begin
				if (instr_ready_i && data_ready_i) begin
					state_d = mem_pkg::ARB_ACK;
				end else if (instr_ready_i) begin
					state_d = mem_pkg::ARB_WAIT_DATA;
				end else if (data_ready_i) begin
					state_d = mem_pkg::ARB_WAIT_INSTR;
				end
			end
			mem_pkg::ARB_WAIT_DATA: begin
				if (data_ready_i) begin
					state_d = mem_pkg::ARB_ACK;
				end
			end
			mem_pkg::ARB_WAIT_INSTR: begin
				if (instr_ready_i) begin
					state_d = mem_pkg::ARB_ACK;
				end
			end
			default: state_d = mem_pkg::ARB_IDLE;
		endcase
	end

	// Mask each port once its access has completed
	assign arb_instr_rd_o = cpu_instr_rd_i && state_q != mem_pkg::ARB_WAIT_DATA
		&& state_q != mem_pkg::ARB_ACK;
	assign arb_data_rd_o  = cpu_data_rd_i && state_q != mem_pkg::ARB_WAIT_INSTR
		&& state_q != mem_pkg::ARB_ACK;
	assign arb_data_wr_o  = cpu_data_wr_i && state_q != mem_pkg::ARB_WAIT_INSTR
		&& state_q != mem_pkg::ARB_ACK;
	assign arb_state_o    = state_q;

	// Copier owns the instruction register while it runs
	assign instr_en = copy_busy_i ? (instr_capture_i && instr_ready_i)
		: (arb_instr_rd_o && instr_ready_i);
	assign data_en  = !copy_busy_i && arb_data_rd_o && data_ready_i;

	// Sampling registers hold the word past the bus cycle
	always_ff @(posedge clk_i) begin
		if (instr_en) begin
			instr_word_o <= instr_data_i;
		end
		if (data_en) begin
			data_word_o <= data_rdata_i;
		end
	end

	a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		state_q == mem_pkg::ARB_ACK |=> state_q == mem_pkg::ARB_IDLE);

endmodule

`default_nettype wire

// ==== verilog/code_copier.sv ====
`timescale 1ns/10ps
`default_nettype none

module code_copier (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  logic                       start_copy_i,
	input  logic                       mem_ready_i,
	input  logic [csr_pkg::ADDR_W-1:0] start_addr_i,
	input  logic [csr_pkg::ADDR_W-1:0] stop_addr_i,
	input  logic                       instr_ready_i,
	input  logic                       data_ready_i,
	output logic                       copy_busy_o,
	output logic                       copy_rd_o,
	output logic                       copy_wr_o,
	output logic                       instr_capture_o,
	output logic                       copy_done_o,
	output logic [csr_pkg::ADDR_W-1:0] copy_addr_o
);

	mem_pkg::copy_state_e       state_q;
	logic [csr_pkg::ADDR_W-1:0] addr_q, next_addr;

	assign next_addr = addr_q + mem_pkg::WORD_BYTES;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			state_q <= mem_pkg::CP_IDLE;
			addr_q  <= '0;
		end else begin
			case (state_q)
				mem_pkg::CP_IDLE: begin
					// Start only between CPU accesses
					if (start_copy_i && mem_ready_i) begin
						addr_q  <= start_addr_i;
						state_q <= mem_pkg::CP_READ_ROM;
					end
				end
				mem_pkg::CP_READ_ROM: begin
					if (instr_ready_i) begin
						state_q <= mem_pkg::CP_WRITE_RAM;
					end
				end
				mem_pkg::CP_WRITE_RAM: begin
					if (data_ready_i) begin
						state_q <= mem_pkg::CP_INCR;
					end
				end
				mem_pkg::CP_INCR: begin
					// Stop word itself is not copied
					addr_q  <= next_addr;
					state_q <= (next_addr == stop_addr_i) ? mem_pkg::CP_DONE
						: mem_pkg::CP_READ_ROM;
				end
				default: state_q <= mem_pkg::CP_IDLE;
			endcase
		end
	end

	assign copy_busy_o     = state_q != mem_pkg::CP_IDLE;
	assign copy_rd_o       = state_q == mem_pkg::CP_READ_ROM;
	assign instr_capture_o = state_q == mem_pkg::CP_READ_ROM;
	assign copy_wr_o       = state_q == mem_pkg::CP_WRITE_RAM;
	assign copy_done_o     = state_q == mem_pkg::CP_DONE;
	assign copy_addr_o     = addr_q;

	a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(copy_rd_o && copy_wr_o));

endmodule

`default_nettype wire

// ==== verilog/bus_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_router (
	input  csr_pkg::boot_src_e         boot_src_i,
	input  logic                       exec_from_copy_i,
	input  mem_pkg::copy_dest_e        copy_dest_i,
	input  logic                       copy_busy_i,
	input  logic                       copy_rd_i,
	input  logic                       copy_wr_i,
	input  logic [csr_pkg::ADDR_W-1:0] copy_addr_i,
	input  logic [csr_pkg::DATA_W-1:0] instr_word_i,
	input  logic                       arb_instr_rd_i,
	input  logic                       arb_data_rd_i,
	input  logic                       arb_data_wr_i,
	input  mem_pkg::arb_state_e        arb_state_i,
	input  logic [csr_pkg::ADDR_W-1:0] cpu_instr_addr_i,
	input  logic [csr_pkg::ADDR_W-1:0] cpu_data_addr_i,
	input  logic [csr_pkg::DATA_W-1:0] cpu_data_wdata_i,
	input  logic [csr_pkg::STRB_W-1:0] cpu_byte_sel_i,
	output logic                       bus_instr_rd_o,
	output logic [csr_pkg::ADDR_W-1:0] bus_instr_addr_o,
	output logic                       bus_data_rd_o,
	output logic                       bus_data_wr_o,
	output logic [csr_pkg::ADDR_W-1:0] bus_data_addr_o,
	output logic [csr_pkg::DATA_W-1:0] bus_data_wdata_o,
	output logic [csr_pkg::STRB_W-1:0] bus_byte_sel_o,
	input  logic                       bus_instr_ready_i,
	input  logic [csr_pkg::DATA_W-1:0] bus_instr_rdata_i,
	input  logic                       bus_data_ready_i,
	output logic [csr_pkg::DATA_W-1:0] cpu_instr_data_o,
	output logic                       mem_ready_o
);

	logic fetch_sram, fetch_ddr, data_req;

	// SRAM keeps its offset bits, DDR gets its region nibble
	function automatic logic [csr_pkg::ADDR_W-1:0] map_addr(input logic to_ddr,
		input logic [csr_pkg::ADDR_W-1:0] addr);
		if (to_ddr) begin
			return {mem_pkg::DDR_REGION, addr[mem_pkg::DDR_OFFS_W-1:0]};
		end
		return {{(csr_pkg::ADDR_W - mem_pkg::SRAM_OFFS_W){1'b0}},
			addr[mem_pkg::SRAM_OFFS_W-1:0]};
	endfunction

	// Boot source before the copy, copy destination after it
	assign fetch_sram = exec_from_copy_i ? (copy_dest_i == mem_pkg::DEST_SRAM)
		: (boot_src_i == csr_pkg::BOOT_SRAM);
	assign fetch_ddr  = exec_from_copy_i ? (copy_dest_i == mem_pkg::DEST_DDR)
		: (boot_src_i == csr_pkg::BOOT_DDR);
	assign data_req   = arb_data_rd_i || arb_data_wr_i;

	// Instruction port, SPI and copy reads pass the address unchanged
	always_comb begin
		bus_instr_rd_o   = copy_busy_i ? copy_rd_i : arb_instr_rd_i;
		bus_instr_addr_o = cpu_instr_addr_i;
		if (copy_busy_i) begin
			bus_instr_addr_o = copy_addr_i;
		end else if (fetch_sram || fetch_ddr) begin
			bus_instr_addr_o = map_addr(fetch_ddr, cpu_instr_addr_i);
		end
	end

	// Data port carries the copied word during a copy
	assign bus_data_rd_o    = copy_busy_i ? 1'b0 : arb_data_rd_i;
	assign bus_data_wr_o    = copy_busy_i ? copy_wr_i : arb_data_wr_i;
	assign bus_data_addr_o  = copy_busy_i ? map_addr(copy_dest_i == mem_pkg::DEST_DDR, copy_addr_i)
		: cpu_data_addr_i;
	assign bus_data_wdata_o = copy_busy_i ? instr_word_i : cpu_data_wdata_i;
	assign bus_byte_sel_o   = copy_busy_i ? {csr_pkg::STRB_W{1'b1}} : cpu_byte_sel_i;

	// Word was sampled earlier when both ports waited
	assign cpu_instr_data_o = (arb_state_i == mem_pkg::ARB_ACK) ? instr_word_i : bus_instr_rdata_i;

	// CPU stall
	always_comb begin
		mem_ready_o = 1'b0;
		if (!copy_busy_i) begin
			case (arb_state_i)
				mem_pkg::ARB_IDLE: begin
					// Concurrent access completes here only if both are ready
					if (arb_instr_rd_i && data_req) begin
						mem_ready_o = bus_instr_ready_i && bus_data_ready_i;
					end else if (data_req) begin
						mem_ready_o = bus_data_ready_i;
					end else begin
						mem_ready_o = bus_instr_ready_i;
					end
				end
				mem_pkg::ARB_ACK: mem_ready_o = 1'b1;
				default: mem_ready_o = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_mem_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_mem_ctrl (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  csr_pkg::boot_src_e         boot_src_i,
	// AXI4-Lite register port
	input  logic                       awvalid_i,
	output logic                       awready_o,
	input  logic [csr_pkg::ADDR_W-1:0] awaddr_i,
	input  logic                       wvalid_i,
	output logic                       wready_o,
	input  logic [csr_pkg::DATA_W-1:0] wdata_i,
	input  logic [csr_pkg::STRB_W-1:0] wstrb_i,
	output logic                       bvalid_o,
	input  logic                       bready_i,
	output logic [1:0]                 bresp_o,
	input  logic                       arvalid_i,
	output logic                       arready_o,
	input  logic [csr_pkg::ADDR_W-1:0] araddr_i,
	output logic                       rvalid_o,
	input  logic                       rready_i,
	output logic [csr_pkg::DATA_W-1:0] rdata_o,
	output logic [1:0]                 rresp_o,
	// CPU side
	output logic                       mem_ready_o,
	input  logic                       cpu_instr_rd_i,
	input  logic [csr_pkg::ADDR_W-1:0] cpu_instr_addr_i,
	output logic [csr_pkg::DATA_W-1:0] cpu_instr_data_o,
	input  logic                       cpu_data_rd_i,
	input  logic                       cpu_data_wr_i,
	input  logic [csr_pkg::ADDR_W-1:0] cpu_data_addr_i,
	input  logic [csr_pkg::DATA_W-1:0] cpu_data_wdata_i,
	input  logic [csr_pkg::STRB_W-1:0] cpu_byte_sel_i,
	output logic [csr_pkg::DATA_W-1:0] cpu_data_o,
	// Instruction bus port
	output logic                       bus_instr_rd_o,
	output logic [csr_pkg::ADDR_W-1:0] bus_instr_addr_o,
	input  logic                       bus_instr_ready_i,
	input  logic [csr_pkg::DATA_W-1:0] bus_instr_rdata_i,
	// Data bus port
	output logic                       bus_data_rd_o,
	output logic                       bus_data_wr_o,
	output logic [csr_pkg::ADDR_W-1:0] bus_data_addr_o,
	output logic [csr_pkg::DATA_W-1:0] bus_data_wdata_o,
	output logic [csr_pkg::STRB_W-1:0] bus_byte_sel_o,
	input  logic                       bus_data_ready_i,
	input  logic [csr_pkg::DATA_W-1:0] bus_data_rdata_i
);

	logic                       start_copy, exec_from_copy, copy_done;
	mem_pkg::copy_dest_e        copy_dest;
	logic [csr_pkg::ADDR_W-1:0] start_addr, stop_addr, copy_addr;
	logic                       copy_busy, copy_rd, copy_wr, instr_capture;
	logic                       arb_instr_rd, arb_data_rd, arb_data_wr;
	mem_pkg::arb_state_e        arb_state;
	logic [csr_pkg::DATA_W-1:0] instr_word;

	axil_csr u_csr (
		.clk_i, .rst_ni,
		.awvalid_i, .awready_o, .awaddr_i,
		.wvalid_i, .wready_o, .wdata_i, .wstrb_i,
		.bvalid_o, .bready_i, .bresp_o,
		.arvalid_i, .arready_o, .araddr_i,
		.rvalid_o, .rready_i, .rdata_o, .rresp_o,
		.boot_src_i,
		.copy_done_i      (copy_done),
		.start_copy_o     (start_copy),
		.copy_dest_o      (copy_dest),
		.start_addr_o     (start_addr),
		.stop_addr_o      (stop_addr),
		.exec_from_copy_o (exec_from_copy)
	);

	// Stall FSM and sampling registers
	access_arbiter u_arb (
		.clk_i, .rst_ni,
		.cpu_instr_rd_i, .cpu_data_rd_i, .cpu_data_wr_i,
		.copy_busy_i     (copy_busy),
		.instr_capture_i (instr_capture),
		.instr_ready_i   (bus_instr_ready_i),
		.instr_data_i    (bus_instr_rdata_i),
		.data_ready_i    (bus_data_ready_i),
		.data_rdata_i    (bus_data_rdata_i),
		.arb_instr_rd_o  (arb_instr_rd),
		.arb_data_rd_o   (arb_data_rd),
		.arb_data_wr_o   (arb_data_wr),
		.arb_state_o     (arb_state),
		.instr_word_o    (instr_word),
		.data_word_o     (cpu_data_o)
	);

	code_copier u_copier (
		.clk_i, .rst_ni,
		.start_copy_i    (start_copy),
		.mem_ready_i     (mem_ready_o),
		.start_addr_i    (start_addr),
		.stop_addr_i     (stop_addr),
		.instr_ready_i   (bus_instr_ready_i),
		.data_ready_i    (bus_data_ready_i),
		.copy_busy_o     (copy_busy),
		.copy_rd_o       (copy_rd),
		.copy_wr_o       (copy_wr),
		.instr_capture_o (instr_capture),
		.copy_done_o     (copy_done),
		.copy_addr_o     (copy_addr)
	);

	// Address mapping, port muxing and CPU stall
	bus_router u_router (
		.boot_src_i,
		.exec_from_copy_i (exec_from_copy),
		.copy_dest_i      (copy_dest),
		.copy_busy_i      (copy_busy),
		.copy_rd_i        (copy_rd),
		.copy_wr_i        (copy_wr),
		.copy_addr_i      (copy_addr),
		.instr_word_i     (instr_word),
		.arb_instr_rd_i   (arb_instr_rd),
		.arb_data_rd_i    (arb_data_rd),
		.arb_data_wr_i    (arb_data_wr),
		.arb_state_i      (arb_state),
		.cpu_instr_addr_i, .cpu_data_addr_i, .cpu_data_wdata_i, .cpu_byte_sel_i,
		.bus_instr_rd_o, .bus_instr_addr_o,
		.bus_data_rd_o, .bus_data_wr_o, .bus_data_addr_o,
		.bus_data_wdata_o, .bus_byte_sel_o,
		.bus_instr_ready_i, .bus_instr_rdata_i, .bus_data_ready_i,
		.cpu_instr_data_o, .mem_ready_o
	);

endmodule

`default_nettype wire

// ==== bench/tb_cpu_mem_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_mem_ctrl;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	csr_pkg::boot_src_e boot = csr_pkg::BOOT_SPI;
	logic awvalid = 0, wvalid = 0, bready = 0, arvalid = 0, rready = 0;
	logic [31:0] awaddr = '0, wdata = '0, araddr = '0;
	logic [3:0] wstrb = '0;
	logic awready, wready, bvalid, arready, rvalid, mem_ready;
	logic [1:0] bresp, rresp;
	logic [31:0] rdata, cpu_instr_data, cpu_data;
	logic instr_rd = 0, data_rd = 0, data_wr = 0;
	logic [31:0] instr_addr = '0, data_addr = '0, data_wdata = '0;
	logic [3:0] byte_sel = '0;
	logic bus_instr_rd, bus_data_rd, bus_data_wr;
	logic [31:0] bus_instr_addr, bus_data_addr, bus_data_wdata;
	logic [3:0] bus_byte_sel;
	// Memory model handshake state
	logic i_ready = 0, d_ready = 0, i_pend = 0, d_pend = 0;
	logic [31:0] i_rdata = '0, d_rdata = '0;
	int i_cnt, d_cnt;
	logic [31:0] dmem [logic [31:0]];
	// Routing state the reference mapping works from
	logic exec_ref = 1'b0;
	mem_pkg::copy_dest_e dest_ref = mem_pkg::DEST_SRAM;

	cpu_mem_ctrl u_dut (
		.clk_i(clk), .rst_ni(rst_n), .boot_src_i(boot),
		.awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
		.wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
		.bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
		.arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
		.rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
		.mem_ready_o(mem_ready), .cpu_instr_rd_i(instr_rd), .cpu_instr_addr_i(instr_addr),
		.cpu_instr_data_o(cpu_instr_data), .cpu_data_rd_i(data_rd), .cpu_data_wr_i(data_wr),
		.cpu_data_addr_i(data_addr), .cpu_data_wdata_i(data_wdata),
		.cpu_byte_sel_i(byte_sel), .cpu_data_o(cpu_data),
		.bus_instr_rd_o(bus_instr_rd), .bus_instr_addr_o(bus_instr_addr),
		.bus_instr_ready_i(i_ready), .bus_instr_rdata_i(i_rdata),
		.bus_data_rd_o(bus_data_rd), .bus_data_wr_o(bus_data_wr),
		.bus_data_addr_o(bus_data_addr), .bus_data_wdata_o(bus_data_wdata),
		.bus_byte_sel_o(bus_byte_sel), .bus_data_ready_i(d_ready),
		.bus_data_rdata_i(d_rdata)
	);

	initial begin
		forever begin
			#5 clk = ~clk;
		end
	end

	// ROM contents and untouched data words are address patterns
	function automatic logic [31:0] rom_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h6b3d_90e5;
	endfunction

	function automatic logic [31:0] dread(input logic [31:0] a);
		return dmem.exists(a) ? dmem[a] : (~a ^ 32'h1357_9bdf);
	endfunction

	// Instruction side sees RAM words once written
	function automatic logic [31:0] imem_read(input logic [31:0] a);
		return dmem.exists(a) ? dmem[a] : rom_word(a);
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
		input logic [3:0] sel);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) r[8*b +: 8] = nw[8*b +: 8];
		end
		return r;
	endfunction

	// Expected fetch address by boot source, exec flag and destination
	function automatic logic [31:0] ref_map(input csr_pkg::boot_src_e src, input logic ex,
		input mem_pkg::copy_dest_e dst, input logic [31:0] a);
		logic to_sram, to_ddr;
		to_sram = (!ex && src == csr_pkg::BOOT_SRAM) || (ex && dst == mem_pkg::DEST_SRAM);
		to_ddr  = (!ex && src == csr_pkg::BOOT_DDR) || (ex && dst == mem_pkg::DEST_DDR);
		if (to_ddr) return {4'h1, a[27:0]};
		if (to_sram) return {15'd0, a[16:0]};
		return a;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s got %08h expected %08h", name, got, exp));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s got %0h expected %0h", name, got, exp));
		end
	endtask

	task automatic check_state(input string name, input csr_pkg::boot_src_e got,
		input csr_pkg::boot_src_e exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s got %0h expected %0h", name, got, exp));
		end
	endtask

	// Instruction model with 0 to 3 wait cycles per request
	initial begin
		forever begin
			@(posedge clk);
			#2;
			if (i_ready) begin
				i_ready = 1'b0;
			end else if (rst_n && bus_instr_rd) begin
				if (!i_pend) begin
					i_pend = 1'b1;
					i_cnt = $urandom % 4;
				end
				if (i_cnt == 0) begin
					i_ready = 1'b1;
					i_rdata = imem_read(bus_instr_addr);
					i_pend = 1'b0;
				end else begin
					i_cnt--;
				end
			end
		end
	end

	// Data model
	initial begin
		forever begin
			@(posedge clk);
			#2;
			if (d_ready) begin
				d_ready = 1'b0;
			end else if (rst_n && (bus_data_rd || bus_data_wr)) begin
				if (!d_pend) begin
					d_pend = 1'b1;
					d_cnt = $urandom % 4;
				end
				if (d_cnt == 0) begin
					d_ready = 1'b1;
					d_rdata = dread(bus_data_addr);
					d_pend = 1'b0;
				end else begin
					d_cnt--;
				end
			end
		end
	end

	// Writes land mid-cycle while ready is high
	initial begin
		forever begin
			@(negedge clk);
			if (d_ready && bus_data_wr) begin
				dmem[bus_data_addr] = merge(dread(bus_data_addr), bus_data_wdata, bus_byte_sel);
			end
			if (u_dut.copy_busy && mem_ready) begin
				stop_with_failure("CPU was released while the code copy was running");
			end
		end
	end

	task automatic axi_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		int t;
		@(posedge clk);
		#1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = a;
		wdata = d;
		wstrb = s;
		bready = 1'b1;
		t = 0;
		// Address and data channels are taken in the same cycle
		do begin
			@(negedge clk);
			if (++t > 20) stop_with_failure("AXI write address and data were never accepted");
		end while (!(awready && wready));
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		t = 0;
		while (!bvalid) begin
			@(negedge clk);
			if (++t > 20) stop_with_failure("AXI write response never arrived");
		end
		check_resp("bresp_o", bresp, csr_pkg::RESP_OKAY);
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] a, output logic [31:0] d);
		int t;
		@(posedge clk);
		#1;
		arvalid = 1'b1;
		araddr = a;
		rready = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			if (++t > 20) stop_with_failure("AXI read address was never accepted");
		end while (!arready);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		t = 0;
		while (!rvalid) begin
			@(negedge clk);
			if (++t > 20) stop_with_failure("AXI read data never arrived");
		end
		d = rdata;
		check_resp("rresp_o", rresp, csr_pkg::RESP_OKAY);
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// One CPU access with any mix of fetch and data read or write
	task automatic cpu_access(input logic fetch, input logic rd, input logic wr,
		input logic [31:0] ia, input logic [31:0] da, input logic [31:0] wd,
		input logic [3:0] sel);
		logic [31:0] exp_ia, exp_i, old;
		int t;
		exp_ia = ref_map(boot, exec_ref, dest_ref, ia);
		exp_i = imem_read(exp_ia);
		old = dread(da);
		@(posedge clk);
		#1;
		instr_rd = fetch;
		data_rd = rd;
		data_wr = wr;
		instr_addr = ia;
		data_addr = da;
		data_wdata = wd;
		byte_sel = sel;
		t = 0;
		do begin
			@(negedge clk);
			if (fetch && bus_instr_rd) check_word("bus_instr_addr_o", bus_instr_addr, exp_ia);
			if (++t > 40) stop_with_failure("mem_ready_o never went high");
		end while (!mem_ready);
		if (fetch) check_word("cpu_instr_data_o", cpu_instr_data, exp_i);
		@(posedge clk);
		#1;
		instr_rd = 1'b0;
		data_rd = 1'b0;
		data_wr = 1'b0;
		if (rd) check_word("cpu_data_o", cpu_data, old);
		if (wr) check_word("data model word", dread(da), merge(old, wd, sel));
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] a;
		int t;
		void'($urandom(32'h26dd_4b72));
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Register block with partial strobes
		axi_write(32'h8, 32'h2000_0100, 4'hf);
		axi_write(32'hc, 32'hffff_ffff, 4'hf);
		axi_write(32'hc, 32'h1234_5678, 4'b0101);
		axi_write(32'h0, 32'hffff_fffc, 4'b0001);
		axi_write(32'h4, 32'hffff_ffff, 4'hf);
		axi_read(32'h8, v);
		check_word("start register", v, 32'h2000_0100);
		axi_read(32'hc, v);
		check_word("stop register", v, 32'hff34_ff78);
		axi_read(32'h0, v);
		check_word("control register", v, 32'h0000_00fc);
		boot = csr_pkg::BOOT_DDR;
		axi_read(32'h4, v);
		check_word("status register", v & 32'hffff_fff9, 32'h0);
		check_state("status boot field", csr_pkg::boot_src_e'(v[2:1]), csr_pkg::BOOT_DDR);

		// Fetch routing for every boot source
		for (int s = 0; s < 3; s++) begin
			boot = csr_pkg::boot_src_e'(s);
			for (int k = 0; k < 4; k++) begin
				a = 32'h2000_0000 | ($urandom & 32'h0fff_fffc);
				cpu_access(1'b1, 1'b0, 1'b0, a, '0, '0, '0);
			end
		end

		// Concurrent fetch and data access under random waits
		boot = csr_pkg::BOOT_SPI;
		for (int k = 0; k < 24; k++) begin
			a = 32'h2000_0000 | ($urandom & 32'hffc);
			v = 32'h3000_0000 | ($urandom & 32'h3c);
			if ($urandom % 2 == 0) begin
				cpu_access(1'b1, 1'b1, 1'b0, a, v, '0, '0);
			end else begin
				cpu_access(1'b1, 1'b0, 1'b1, a, v, $urandom, 4'($urandom % 15 + 1));
			end
		end

		// Code copy into DDR is started by the next CPU access
		axi_write(32'hc, 32'h2000_0120, 4'hf);
		axi_write(32'h0, 32'h0000_0003, 4'hf);
		cpu_access(1'b1, 1'b0, 1'b0, 32'h2000_0040, '0, '0, '0);
		t = 0;
		do begin
			axi_read(32'h4, v);
			if (++t > 100) stop_with_failure("Copy never set the exec flag");
		end while (!v[csr_pkg::STAT_EXEC_BIT]);
		axi_read(32'h0, v);
		check_word("control start bit", {31'd0, v[csr_pkg::CTRL_START_BIT]}, 32'h0);
		exec_ref = 1'b1;
		dest_ref = mem_pkg::DEST_DDR;
		for (a = 32'h2000_0100; a < 32'h2000_0120; a += 4) begin
			check_word("copied word", dread(ref_map(boot, 1'b1, dest_ref, a)), rom_word(a));
		end

		// Code now runs from the copy
		for (a = 32'h2000_0100; a < 32'h2000_0120; a += 4) begin
			cpu_access(1'b1, 1'b0, 1'b0, a, '0, '0, '0);
			check_word("fetched copy", cpu_instr_data, rom_word(a));
		end

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/csr_pkg.sv
verilog/mem_pkg.sv
verilog/axil_csr.sv
verilog/access_arbiter.sv
verilog/code_copier.sv
verilog/bus_router.sv
verilog/cpu_mem_ctrl.sv
bench/tb_cpu_mem_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_mem_ctrl
FILELIST  ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check the log"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
